//--- Bender.yml
package:
  name: mips_pipe

sources:
  - design/mips_pkg.sv
  - design/stage_reg.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/mips_top.sv
  - target: simulation
    files:
      - sim/tb_mips_top.sv

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  if_id_t    id_in,
	input  fwd_t      wb,
	input  logic      ex_load,
	input  reg_addr_t ex_dest,
	output id_ex_t    id_out,
	output logic      stall,
	output logic      jump_taken,
	output data_t     jump_target,
	input  reg_addr_t dbg_reg_addr,
	output data_t     dbg_reg_data
);

	data_t     regs [32];
	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t dest;
	ctrl_t     ctrl;
	data_t     imm;
	data_t     rs_val;
	logic      uses_rs;
	logic      uses_rt;

	// write-back bypasses the array, never for r0
	function automatic data_t rf_read(reg_addr_t a, data_t stored, fwd_t w);
		if (a != '0 && w.reg_write && w.dest == a)
			return w.value;
		return stored;
	endfunction

	// array cleared on reset, r0 never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.reg_write && wb.dest != '0) begin
			regs[wb.dest] <= wb.value;
		end
	end

	// instruction fields
	assign opcode = id_in.instr[31:26];
	assign funct  = id_in.instr[5:0];
	assign rs     = id_in.instr[25:21];
	assign rt     = id_in.instr[20:16];
	assign imm    = {{16{id_in.instr[15]}}, id_in.instr[15:0]};
	assign rs_val = rf_read(rs, regs[rs], wb);

	////////////////////
	// control decode
	////////////////////
	always_comb begin
		ctrl    = '0;
		dest    = id_in.instr[15:11];
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				uses_rt        = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct)
					FN_ADD:  ctrl.alu_op = alu_add;
					FN_SUB:  ctrl.alu_op = alu_sub;
					FN_AND:  ctrl.alu_op = alu_and;
					FN_OR:   ctrl.alu_op = alu_or;
					FN_SLT:  ctrl.alu_op = alu_slt;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				dest           = rt;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LW: begin
				dest            = rt;
				ctrl.alu_src    = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			OP_SW: begin
				uses_rt        = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ: begin
				uses_rt     = 1'b1;
				ctrl.alu_op = alu_sub;
				ctrl.branch = 1'b1;
			end
			OP_HALT: begin
				uses_rs   = 1'b0;
				ctrl.halt = 1'b1;
			end
			// j and unknown opcodes read nothing
			default: uses_rs = 1'b0;
		endcase
		// bubbles carry no control
		if (!id_in.valid)
			ctrl = '0;
	end

	assign id_out = '{valid: id_in.valid, ctrl: ctrl, pc_next: id_in.pc_next,
		rs_val: rs_val, rt_val: rf_read(rt, regs[rt], wb), imm: imm,
		rs: rs, rt: rt, dest: dest};

	// j resolved here, one slot lost
	assign jump_taken  = id_in.valid && (opcode == OP_J);
	assign jump_target = {id_in.pc_next[31:28], id_in.instr[25:0], 2'b00};

	// load in execute feeding this instruction
	assign stall = id_in.valid && ex_load && (ex_dest != '0) &&
		((uses_rs && ex_dest == rs) || (uses_rt && ex_dest == rt));

	assign dbg_reg_data = rf_read(dbg_reg_addr, regs[dbg_reg_addr], wb);

	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rs == '0) |-> (rs_val == '0))
		else $error("decode_stage: r0 read as nonzero");

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
	input  id_ex_t    ex_in,
	input  fwd_t      fwd_mem,
	input  fwd_t      fwd_wb,
	output ex_mem_t   ex_out,
	output logic      ex_load,
	output reg_addr_t ex_dest
);

	data_t op_a;
	data_t op_b_reg;
	data_t op_b;
	data_t alu_res;

	// newer result wins, r0 never forwarded
	function automatic data_t fwd_pick(reg_addr_t r, data_t v, fwd_t m, fwd_t w);
		if (r != '0 && m.reg_write && m.dest == r)
			return m.value;
		if (r != '0 && w.reg_write && w.dest == r)
			return w.value;
		return v;
	endfunction

	assign op_a     = fwd_pick(ex_in.rs, ex_in.rs_val, fwd_mem, fwd_wb);
	assign op_b_reg = fwd_pick(ex_in.rt, ex_in.rt_val, fwd_mem, fwd_wb);
	// immediate for addi, lw, sw
	assign op_b     = ex_in.ctrl.alu_src ? ex_in.imm : op_b_reg;

	////////////////////
	// alu
	////////////////////
	always_comb begin
		case (ex_in.ctrl.alu_op)
			alu_add: alu_res = op_a + op_b;
			alu_sub: alu_res = op_a - op_b;
			alu_and: alu_res = op_a & op_b;
			alu_or:  alu_res = op_a | op_b;
			alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_res = '0;
		endcase
	end

	// branch target relative to pc+4, zero flag for beq
	assign ex_out = '{valid: ex_in.valid, ctrl: ex_in.ctrl, alu_res: alu_res,
		store_val: op_b_reg, br_target: ex_in.pc_next + {ex_in.imm[29:0], 2'b00},
		zero: (alu_res == '0), dest: ex_in.dest};

	// hazard info back to decode
	assign ex_load = ex_in.valid && ex_in.ctrl.mem_read;
	assign ex_dest = ex_in.dest;

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load_mode,
	input  logic       imem_we,
	input  imem_addr_t imem_addr,
	input  data_t      imem_wdata,
	input  logic       stall,
	input  logic       jump_taken,
	input  data_t      jump_target,
	input  logic       branch_taken,
	input  data_t      br_target,
	output data_t      pc,
	output if_id_t     if_out
);

	data_t imem [IMEM_WORDS];
	data_t instr;
	data_t pc_plus4;
	data_t pc_next;
	logic  halt_fetch;

	// program load from outside
	always_ff @(posedge clk) begin
		if (load_mode && imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// word index of pc
	assign instr      = imem[pc[8:2]];
	assign pc_plus4   = pc + 32'd4;
	assign halt_fetch = (instr[31:26] == OP_HALT);

	////////////////////
	// next pc
	////////////////////
	always_comb begin
		if (load_mode)
			pc_next = '0;
		else if (branch_taken)
			pc_next = br_target;
		else if (jump_taken)
			pc_next = jump_target;
		// halt freezes until a redirect
		else if (stall || halt_fetch)
			pc_next = pc;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	assign if_out = '{valid: !load_mode, pc_next: pc_plus4, instr: instr};

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("fetch_stage: pc not word aligned");

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  ex_mem_t    mem_in,
	input  logic       load_mode,
	output logic       branch_taken,
	output data_t      br_target,
	output fwd_t       fwd_mem,
	output mem_wb_t    wb_out,
	input  mem_wb_t    wb_in,
	output logic       halted,
	input  dmem_addr_t dbg_mem_addr,
	output data_t      dbg_mem_data
);

	data_t dmem [DMEM_WORDS];
	data_t rdata;
	data_t result;
	logic  halted_q;

	// synchronous write, word addressed
	always_ff @(posedge clk) begin
		if (mem_in.valid && mem_in.ctrl.mem_write)
			dmem[mem_in.alu_res[7:2]] <= mem_in.store_val;
	end

	assign rdata        = dmem[mem_in.alu_res[7:2]];
	assign result       = mem_in.ctrl.mem_to_reg ? rdata : mem_in.alu_res;
	assign dbg_mem_data = dmem[dbg_mem_addr];

	// beq resolved here
	assign branch_taken = mem_in.valid && mem_in.ctrl.branch && mem_in.zero;
	assign br_target    = mem_in.br_target;

	// carries load data, so no second stall cycle
	assign fwd_mem = '{reg_write: mem_in.valid && mem_in.ctrl.reg_write,
		dest: mem_in.dest, value: result};
	assign wb_out  = '{valid: mem_in.valid, reg_write: mem_in.ctrl.reg_write,
		halt: mem_in.ctrl.halt, dest: mem_in.dest, result: result};

	////////////////////
	// halt latch
	////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			halted_q <= 1'b0;
		else if (load_mode)
			halted_q <= 1'b0;
		else if (wb_in.valid && wb_in.halt)
			halted_q <= 1'b1;
	end

	// visible as soon as the halt sits in mem_wb
	assign halted = halted_q || (wb_in.valid && wb_in.halt);

	// shadow of a taken beq reaches here as a bubble
	a_no_store_after_branch: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |=> !(mem_in.valid && mem_in.ctrl.mem_write))
		else $error("memory_stage: store in the shadow of a taken branch");

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

	////////////////////
	// widths and depths
	////////////////////
	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  imem_addr_t;
	typedef logic [5:0]  dmem_addr_t;

	localparam int IMEM_WORDS = 128;
	localparam int DMEM_WORDS = 64;

	////////////////////
	// opcodes, funct
	////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;
	// not a real mips opcode, stops the core
	localparam logic [5:0] OP_HALT  = 6'h3f;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_t;

	// 10 bits of control, travels with the instruction
	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;
		logic    branch;
		logic    halt;
	} ctrl_t;

	////////////////////
	// stage payloads
	////////////////////
	typedef struct packed {
		logic  valid;
		data_t pc_next;
		data_t instr;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		data_t     pc_next;
		data_t     rs_val;
		data_t     rt_val;
		data_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		data_t     alu_res;
		data_t     store_val;
		data_t     br_target;
		logic      zero;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		logic      reg_write;
		logic      halt;
		reg_addr_t dest;
		data_t     result;
	} mem_wb_t;

	// one forwarding source
	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		data_t     value;
	} fwd_t;

endpackage

//--- design/mips_top.sv
`timescale 1ns/1ps

module mips_top import mips_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load_mode,
	input  logic       imem_we,
	input  imem_addr_t imem_addr,
	input  data_t      imem_wdata,
	input  reg_addr_t  dbg_reg_addr,
	output data_t      dbg_reg_data,
	input  dmem_addr_t dbg_mem_addr,
	output data_t      dbg_mem_data,
	output data_t      pc,
	output logic       halted
);

	// d side from the stage, q side into the next one
	if_id_t    if_d, if_q;
	id_ex_t    id_d, id_q;
	ex_mem_t   ex_d, ex_q;
	mem_wb_t   mem_d, mem_q;
	fwd_t      fwd_mem;
	fwd_t      fwd_wb;
	logic      stall;
	logic      jump_taken;
	logic      branch_taken;
	logic      ex_load;
	data_t     jump_target;
	data_t     br_target;
	reg_addr_t ex_dest;

	// write-back source, feeds decode and execute
	assign fwd_wb = '{reg_write: mem_q.valid && mem_q.reg_write,
		dest: mem_q.dest, value: mem_q.result};

	////////////////////
	// stages
	////////////////////
	fetch_stage u_fetch (.clk, .rst_n, .load_mode, .imem_we, .imem_addr, .imem_wdata,
		.stall, .jump_taken, .jump_target, .branch_taken, .br_target, .pc, .if_out(if_d));

	decode_stage u_decode (.clk, .rst_n, .id_in(if_q), .wb(fwd_wb), .ex_load, .ex_dest,
		.id_out(id_d), .stall, .jump_taken, .jump_target, .dbg_reg_addr, .dbg_reg_data);

	execute_stage u_execute (.ex_in(id_q), .fwd_mem, .fwd_wb, .ex_out(ex_d),
		.ex_load, .ex_dest);

	memory_stage u_memory (.clk, .rst_n, .mem_in(ex_q), .load_mode, .branch_taken,
		.br_target, .fwd_mem, .wb_out(mem_d), .wb_in(mem_q), .halted,
		.dbg_mem_addr, .dbg_mem_data);

	////////////////////
	// pipeline registers
	////////////////////
	// stall only holds when no branch or load flush is pending
	stage_reg #(.payload_t(if_id_t)) u_if_id (.clk, .rst_n,
		.hold(stall && !branch_taken && !load_mode),
		.flush(load_mode || branch_taken || jump_taken), .d(if_d), .q(if_q));

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (.clk, .rst_n, .hold(1'b0),
		.flush(load_mode || branch_taken || stall), .d(id_d), .q(id_q));

	stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (.clk, .rst_n, .hold(1'b0),
		.flush(load_mode || branch_taken), .d(ex_d), .q(ex_q));

	stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (.clk, .rst_n, .hold(1'b0),
		.flush(load_mode), .d(mem_d), .q(mem_q));

endmodule

//--- design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// flush beats hold, bubble is all zeros
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			q <= '0;
		else if (flush)
			q <= '0;
		else if (!hold)
			q <= d;
	end

	// top masks hold during branch and load mode
	a_hold_flush: assert property (@(posedge clk) disable iff (!rst_n) !(hold && flush))
		else $error("stage_reg: hold and flush both high");

endmodule

//--- mips_pipe.f
design/mips_pkg.sv
design/stage_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_top.sv
sim/tb_mips_top.sv

//--- sim/tb_mips_top.sv
`timescale 1ns/1ps

module tb_mips_top import mips_pkg::*; ();

	logic       clk;
	logic       rst_n;
	logic       load_mode;
	logic       imem_we;
	imem_addr_t imem_addr;
	data_t      imem_wdata;
	reg_addr_t  dbg_reg_addr;
	data_t      dbg_reg_data;
	dmem_addr_t dbg_mem_addr;
	data_t      dbg_mem_data;
	data_t      pc;
	logic       halted;

	// program image for the next load
	data_t       prog [$];
	logic [31:0] lfsr = 32'hf740;
	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;

	mips_top uut (.*);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// encoders, lfsr
	////////////////////
	function automatic data_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic data_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic data_t widen(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit
	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	////////////////////
	// bus helpers
	////////////////////
	task automatic load_program();
		@(negedge clk);
		load_mode = 1'b1;
		foreach (prog[i]) begin
			imem_we    = 1'b1;
			imem_addr  = imem_addr_t'(i);
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we   = 1'b0;
		// first fetch in the next cycle
		load_mode = 1'b0;
	endtask

	task automatic wait_halted(input string what);
		int n;
		n = 0;
		// 200 cycles is far beyond any program here
		while (halted !== 1'b1 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("timeout at %0t ns: %s program never raised halted", $time, what);
		end
	endtask

	task automatic compare_word(input string name, input data_t got, input data_t exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// debug reads are combinational, sample a cycle later
	task automatic verify_reg(input reg_addr_t r, input data_t exp);
		@(negedge clk);
		dbg_reg_addr = r;
		@(negedge clk);
		compare_word($sformatf("dbg_reg_data[r%0d]", r), dbg_reg_data, exp);
	endtask

	task automatic mem_holds(input dmem_addr_t w, input data_t exp);
		@(negedge clk);
		dbg_mem_addr = w;
		@(negedge clk);
		compare_word($sformatf("dbg_mem_data[%0d]", w), dbg_mem_data, exp);
	endtask

	task automatic finish_test(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - mark);
		end
	endtask

	////////////////////
	// tests
	////////////////////
	// each op reads the result just before it
	task automatic alu_chain_test();
		logic [15:0] ia;
		logic [15:0] ib;
		data_t       a, b, e3, e4, e5, e6, e7;
		int          mark;
		mark = errors;
		draw_bits(16, ia);
		draw_bits(16, ib);
		a  = widen(ia);
		b  = widen(ib);
		e3 = a + b;
		e4 = e3 - a;
		e5 = e4 & e3;
		e6 = e5 | b;
		e7 = ($signed(e6) < $signed(a)) ? 32'd1 : 32'd0;
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, ia));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd2, ib));
		prog.push_back(r_type(5'd1, 5'd2, 5'd3, FN_ADD));
		prog.push_back(r_type(5'd3, 5'd1, 5'd4, FN_SUB));
		prog.push_back(r_type(5'd4, 5'd3, 5'd5, FN_AND));
		prog.push_back(r_type(5'd5, 5'd2, 5'd6, FN_OR));
		prog.push_back(r_type(5'd6, 5'd1, 5'd7, FN_SLT));
		prog.push_back({OP_HALT, 26'd0});
		load_program();
		wait_halted("alu chain");
		verify_reg(5'd3, e3);
		verify_reg(5'd4, e4);
		verify_reg(5'd5, e5);
		verify_reg(5'd6, e6);
		verify_reg(5'd7, e7);
		finish_test("alu chain", mark);
	endtask

	// add right after lw, one stall
	task automatic load_use_test();
		logic [15:0] iv;
		logic [15:0] slot;
		data_t       v;
		int          mark;
		mark = errors;
		draw_bits(16, iv);
		draw_bits(4, slot);
		v = widen(iv);
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, iv));
		prog.push_back(i_type(OP_SW, 5'd0, 5'd1, {slot[13:0], 2'b00}));
		prog.push_back(i_type(OP_LW, 5'd0, 5'd8, {slot[13:0], 2'b00}));
		prog.push_back(r_type(5'd8, 5'd1, 5'd9, FN_ADD));
		prog.push_back({OP_HALT, 26'd0});
		load_program();
		wait_halted("load-use");
		verify_reg(5'd8, v);
		verify_reg(5'd9, v + v);
		mem_holds(dmem_addr_t'(slot), v);
		finish_test("load-use", mark);
	endtask

	// not taken at 2, taken at 10 to 14
	task automatic branch_test();
		int mark;
		mark = errors;
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd3, 16'd4));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd4, 16'd6));
		prog.push_back(i_type(OP_BEQ, 5'd3, 5'd4, 16'd2));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd14, 16'd21));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd15, 16'd22));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'd5));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd2, 16'd5));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd10, 16'd1));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd11, 16'd1));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd12, 16'd1));
		prog.push_back(i_type(OP_BEQ, 5'd1, 5'd2, 16'd3));
		// shadow of the taken branch
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd10, 16'd77));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd11, 16'd77));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd12, 16'd77));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd13, 16'd55));
		prog.push_back({OP_HALT, 26'd0});
		load_program();
		wait_halted("beq");
		verify_reg(5'd14, 32'd21);
		verify_reg(5'd15, 32'd22);
		verify_reg(5'd10, 32'd1);
		verify_reg(5'd11, 32'd1);
		verify_reg(5'd12, 32'd1);
		verify_reg(5'd13, 32'd55);
		finish_test("beq", mark);
	endtask

	task automatic jump_test();
		int mark;
		mark = errors;
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd16, 16'd3));
		prog.push_back({OP_J, 26'd3});
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd16, 16'd99));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd17, 16'd8));
		prog.push_back({OP_HALT, 26'd0});
		load_program();
		wait_halted("jump");
		verify_reg(5'd16, 32'd3);
		verify_reg(5'd17, 32'd8);
		finish_test("jump", mark);
	endtask

	// halt at word 2, pc parks on it
	task automatic halt_test();
		int mark;
		mark = errors;
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd20, 16'd7));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd21, 16'd6));
		prog.push_back({OP_HALT, 26'd0});
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd20, 16'd99));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd21, 16'd98));
		load_program();
		wait_halted("halt");
		compare_word("pc", pc, 32'd8);
		repeat (5) @(negedge clk);
		compare_word("halted", {31'd0, halted}, 32'd1);
		compare_word("pc", pc, 32'd8);
		verify_reg(5'd20, 32'd7);
		verify_reg(5'd21, 32'd6);
		finish_test("halt", mark);
	endtask

	task automatic reset_test();
		int mark;
		mark = errors;
		@(negedge clk);
		rst_n     = 1'b0;
		load_mode = 1'b0;
		repeat (3) @(negedge clk);
		compare_word("pc", pc, 32'd0);
		compare_word("halted", {31'd0, halted}, 32'd0);
		// keep the core parked until the loader runs
		load_mode = 1'b1;
		rst_n     = 1'b1;
		prog.delete();
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd0, 16'd123));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd23, 16'd5));
		prog.push_back(r_type(5'd0, 5'd23, 5'd24, FN_ADD));
		prog.push_back({OP_HALT, 26'd0});
		load_program();
		wait_halted("reset");
		verify_reg(5'd0, 32'd0);
		verify_reg(5'd24, 32'd5);
		finish_test("reset", mark);
	endtask

	initial begin
		rst_n        = 1'b0;
		load_mode    = 1'b0;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_wdata   = '0;
		dbg_reg_addr = '0;
		dbg_mem_addr = '0;
		repeat (3) @(negedge clk);
		load_mode = 1'b1;
		rst_n     = 1'b1;
		alu_chain_test();
		load_use_test();
		branch_test();
		jump_test();
		halt_test();
		reset_test();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
